/* logic/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // bus widths
    localparam int addr_w = 30;
    localparam int data_w = 32;
    localparam int sel_w = 4;

    // address split, page view and register view
    localparam int page_w = 9;
    localparam int page_off_w = addr_w - page_w;
    localparam int reg_idx_w = 4;
    localparam int reg_upper_w = addr_w - reg_idx_w;

    // one word address, decoded by page or by register index
    typedef union packed {
        struct packed {
            logic [page_w-1:0]     page;
            logic [page_off_w-1:0] offset;
        } page_view;
        struct packed {
            logic [reg_upper_w-1:0] upper;
            logic [reg_idx_w-1:0]   index;
        } reg_view;
    } bus_addr_t;

    // address map
    localparam logic [page_w-1:0] page_mem = 9'h000;
    localparam logic [page_w-1:0] page_sys = 9'h001;
    localparam logic [addr_w-1:0] addr_sw_led = 30'h400001;

    // on-chip memory depth, in word address bits
    localparam int ram_depth_log2 = 8;

    // build identifier
    localparam logic [data_w-1:0] sys_id_value = 32'h20191028;

    // system register indices
    localparam logic [reg_idx_w-1:0] sys_reg_id = 4'h0;
    localparam logic [reg_idx_w-1:0] sys_reg_scratch = 4'h1;
    localparam logic [reg_idx_w-1:0] sys_reg_err_addr = 4'h2;
    localparam logic [reg_idx_w-1:0] sys_reg_counter = 4'h3;
    localparam logic [reg_idx_w-1:0] sys_reg_irq = 4'h4;

    // switches and leds
    localparam int io_w = 16;

endpackage

`default_nettype wire

/* logic/wb_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
    import soc_bus_pkg::*;

    // request
    logic cyc;
    logic stb;
    logic we;
    bus_addr_t addr;
    logic [data_w-1:0] wdata;
    logic [sel_w-1:0] sel;

    // response
    logic ack;
    logic err;
    logic stall;
    logic [data_w-1:0] rdata;

    modport master (
        output cyc, stb, we, addr, wdata, sel,
        input  ack, err, stall, rdata
    );

    modport slave (
        input  cyc, stb, we, addr, wdata, sel,
        output ack, err, stall, rdata
    );

    // simple slaves never stall and never fault
    modport device (
        input  cyc, stb, we, addr, wdata, sel,
        output ack, rdata
    );

endinterface

`default_nettype wire

/* logic/wb_priority_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_priority_arbiter (
    input wire logic i_clk,
    input wire logic i_reset,
    wb_bus_if.slave  i_a,
    wb_bus_if.slave  i_b,
    wb_bus_if.master o_bus
);
    import soc_bus_pkg::*;

    // high while port a (processor) owns the bus
    logic owner_a;
    logic owner_cyc;

    assign owner_cyc = owner_a ? i_a.cyc : i_b.cyc;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_a <= 1'b1;
        end else if (!owner_cyc) begin
            // owner idle, port a keeps priority unless only b asks
            owner_a <= i_a.cyc || !i_b.cyc;
        end
    end

    // request path, combinational
    always_comb begin
        if (owner_a) begin
            o_bus.cyc = i_a.cyc;
            o_bus.stb = i_a.stb;
            o_bus.we = i_a.we;
            o_bus.addr = i_a.addr;
            o_bus.wdata = i_a.wdata;
            o_bus.sel = i_a.sel;
        end else begin
            o_bus.cyc = i_b.cyc;
            o_bus.stb = i_b.stb;
            o_bus.we = i_b.we;
            o_bus.addr = i_b.addr;
            o_bus.wdata = i_b.wdata;
            o_bus.sel = i_b.sel;
        end
    end

    // responses go to the owner only
    assign i_a.ack = owner_a && o_bus.ack;
    assign i_a.err = owner_a && o_bus.err;
    assign i_b.ack = !owner_a && o_bus.ack;
    assign i_b.err = !owner_a && o_bus.err;

    // read data is shared, valid only alongside ack
    assign i_a.rdata = o_bus.rdata;
    assign i_b.rdata = o_bus.rdata;

    // non-owner is held off while it strobes
    assign i_a.stall = owner_a ? o_bus.stall : i_a.stb;
    assign i_b.stall = owner_a ? i_b.stb : o_bus.stall;

    // a response lands only while the owning master still holds its cycle
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_bus.ack || o_bus.err) |-> owner_cyc);

endmodule

`default_nettype wire

/* logic/bus_address_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_address_decoder (
    input wire logic i_clk,
    input wire logic i_reset,
    wb_bus_if.slave  i_bus,
    wb_bus_if        o_mem,
    wb_bus_if        o_sys,
    wb_bus_if        o_io,
    output logic     o_err_pulse,
    output soc_bus_pkg::bus_addr_t o_err_addr
);
    import soc_bus_pkg::*;

    logic mem_sel;
    logic sys_sel;
    logic io_sel;
    logic none_sel;
    logic ack_q;
    logic err_q;
    logic [data_w-1:0] rdata_q;
    bus_addr_t err_addr_q;

    // page decode, the switch port sits on a single word
    assign mem_sel = i_bus.addr.page_view.page == page_mem;
    assign sys_sel = i_bus.addr.page_view.page == page_sys;
    assign io_sel = i_bus.addr == addr_sw_led;
    assign none_sel = !mem_sel && !sys_sel && !io_sel;

    // fan the request out with strobe gated per device
    assign o_mem.cyc = i_bus.cyc;
    assign o_mem.stb = i_bus.stb && mem_sel;
    assign o_mem.we = i_bus.we;
    assign o_mem.addr = i_bus.addr;
    assign o_mem.wdata = i_bus.wdata;
    assign o_mem.sel = i_bus.sel;

    assign o_sys.cyc = i_bus.cyc;
    assign o_sys.stb = i_bus.stb && sys_sel;
    assign o_sys.we = i_bus.we;
    assign o_sys.addr = i_bus.addr;
    assign o_sys.wdata = i_bus.wdata;
    assign o_sys.sel = i_bus.sel;

    assign o_io.cyc = i_bus.cyc;
    assign o_io.stb = i_bus.stb && io_sel;
    assign o_io.we = i_bus.we;
    assign o_io.addr = i_bus.addr;
    assign o_io.wdata = i_bus.wdata;
    assign o_io.sel = i_bus.sel;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= o_mem.ack || o_sys.ack || o_io.ack;
            err_q <= i_bus.stb && none_sel;
        end
    end

    // merged read data, zero when nobody answered
    always_ff @(posedge i_clk) begin
        if (o_mem.ack) begin
            rdata_q <= o_mem.rdata;
        end else if (o_sys.ack) begin
            rdata_q <= o_sys.rdata;
        end else if (o_io.ack) begin
            rdata_q <= o_io.rdata;
        end else begin
            rdata_q <= '0;
        end
    end

    // faulting address for the system registers
    always_ff @(posedge i_clk) begin
        if (i_bus.stb && none_sel) begin
            err_addr_q <= i_bus.addr;
        end
    end

    assign i_bus.ack = ack_q;
    assign i_bus.err = err_q;
    assign i_bus.rdata = rdata_q;
    assign i_bus.stall = 1'b0;
    assign o_err_pulse = err_q;
    assign o_err_addr = err_addr_q;

    assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus.stb |-> $onehot0({mem_sel, sys_sel, io_sel}));

    // device acks and the decoder's own err never coincide
    assert property (@(posedge i_clk) disable iff (i_reset) !(ack_q && err_q));

endmodule

`default_nettype wire

/* logic/system_info_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module system_info_regs (
    input wire logic i_clk,
    input wire logic i_reset,
    wb_bus_if.device i_bus,
    input wire logic i_err_pulse,
    input wire soc_bus_pkg::bus_addr_t i_err_addr,
    output logic     o_irq
);
    import soc_bus_pkg::*;

    logic ack_q;
    logic irq_q;
    logic [data_w-1:0] scratch_q;
    logic [data_w-1:0] counter_q;
    logic [data_w-1:0] rdata_q;
    bus_addr_t err_addr_q;
    logic wr_en;

    assign wr_en = i_bus.stb && i_bus.we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            ack_q <= i_bus.stb;
            if (wr_en && i_bus.addr.reg_view.index == sys_reg_irq) begin
                irq_q <= i_bus.wdata[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && i_bus.addr.reg_view.index == sys_reg_scratch) begin
            scratch_q <= i_bus.wdata;
        end
        if (i_err_pulse) begin
            err_addr_q <= i_err_addr;
        end
    end

    // cycles since reset, top bit sticks once reached
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            counter_q <= '0;
        end else if (!counter_q[data_w-1]) begin
            counter_q <= counter_q + 1'b1;
        end else begin
            counter_q[data_w-2:0] <= counter_q[data_w-2:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus.stb) begin
            case (i_bus.addr.reg_view.index)
                sys_reg_id:       rdata_q <= sys_id_value;
                sys_reg_scratch:  rdata_q <= scratch_q;
                // reported as a byte address
                sys_reg_err_addr: rdata_q <= {err_addr_q, 2'b00};
                sys_reg_counter:  rdata_q <= counter_q;
                sys_reg_irq:      rdata_q <= {{(data_w-1){1'b0}}, irq_q};
                default:          rdata_q <= '0;
            endcase
        end
    end

    assign i_bus.ack = ack_q;
    assign i_bus.rdata = rdata_q;
    assign o_irq = irq_q;

endmodule

`default_nettype wire

/* logic/switch_led_port.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_led_port (
    input wire logic i_clk,
    input wire logic i_reset,
    wb_bus_if.device i_bus,
    input wire logic [soc_bus_pkg::io_w-1:0] i_switches,
    output logic [soc_bus_pkg::io_w-1:0]     o_leds
);
    import soc_bus_pkg::*;

    logic ack_q;
    logic [io_w-1:0] leds_q;
    logic [data_w-1:0] rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            leds_q <= '0;
        end else begin
            ack_q <= i_bus.stb;
            // led register takes the low half of the write
            if (i_bus.stb && i_bus.we) begin
                leds_q <= i_bus.wdata[io_w-1:0];
            end
        end
    end

    // switches sampled on the strobe, zero-extended
    always_ff @(posedge i_clk) begin
        if (i_bus.stb) begin
            rdata_q <= {{(data_w-io_w){1'b0}}, i_switches};
        end
    end

    assign i_bus.ack = ack_q;
    assign i_bus.rdata = rdata_q;
    assign o_leds = leds_q;

endmodule

`default_nettype wire

/* logic/block_ram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module block_ram_slave (
    input wire logic i_clk,
    wb_bus_if.device i_bus
);
    import soc_bus_pkg::*;

    logic [data_w-1:0] mem [2**ram_depth_log2];
    logic [ram_depth_log2-1:0] word_idx;
    logic [data_w-1:0] rdata_q;
    logic ack_q = 1'b0;

    // low word bits only, higher offsets alias
    assign word_idx = i_bus.addr[ram_depth_log2-1:0];

    always_ff @(posedge i_clk) begin
        if (i_bus.stb && i_bus.we) begin
            for (int b = 0; b < sel_w; b++) begin
                if (i_bus.sel[b]) begin
                    mem[word_idx][8*b +: 8] <= i_bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge i_clk) begin
        rdata_q <= mem[word_idx];
        ack_q <= i_bus.stb;
    end

    assign i_bus.ack = ack_q;
    assign i_bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* logic/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input wire logic i_clk,
    input wire logic i_reset,
    // processor port
    input wire logic i_cpu_cyc,
    input wire logic i_cpu_stb,
    input wire logic i_cpu_we,
    input wire logic [soc_bus_pkg::addr_w-1:0] i_cpu_addr,
    input wire logic [soc_bus_pkg::data_w-1:0] i_cpu_data,
    input wire logic [soc_bus_pkg::sel_w-1:0]  i_cpu_sel,
    output logic o_cpu_ack,
    output logic o_cpu_stall,
    output logic o_cpu_err,
    output logic [soc_bus_pkg::data_w-1:0] o_cpu_data,
    // debug port
    input wire logic i_dbg_cyc,
    input wire logic i_dbg_stb,
    input wire logic i_dbg_we,
    input wire logic [soc_bus_pkg::addr_w-1:0] i_dbg_addr,
    input wire logic [soc_bus_pkg::data_w-1:0] i_dbg_data,
    input wire logic [soc_bus_pkg::sel_w-1:0]  i_dbg_sel,
    output logic o_dbg_ack,
    output logic o_dbg_stall,
    output logic o_dbg_err,
    output logic [soc_bus_pkg::data_w-1:0] o_dbg_data,
    // board io
    input wire logic [soc_bus_pkg::io_w-1:0] i_switches,
    output logic [soc_bus_pkg::io_w-1:0]     o_leds,
    output logic o_irq
);
    import soc_bus_pkg::*;

    wb_bus_if cpu_bus ();
    wb_bus_if dbg_bus ();
    wb_bus_if sys_bus ();
    wb_bus_if mem_bus ();
    wb_bus_if sys_regs_bus ();
    wb_bus_if io_bus ();

    logic err_pulse;
    bus_addr_t err_addr;

    assign cpu_bus.cyc = i_cpu_cyc;
    assign cpu_bus.stb = i_cpu_stb;
    assign cpu_bus.we = i_cpu_we;
    assign cpu_bus.addr = i_cpu_addr;
    assign cpu_bus.wdata = i_cpu_data;
    assign cpu_bus.sel = i_cpu_sel;
    assign o_cpu_ack = cpu_bus.ack;
    assign o_cpu_stall = cpu_bus.stall;
    assign o_cpu_err = cpu_bus.err;
    assign o_cpu_data = cpu_bus.rdata;

    assign dbg_bus.cyc = i_dbg_cyc;
    assign dbg_bus.stb = i_dbg_stb;
    assign dbg_bus.we = i_dbg_we;
    assign dbg_bus.addr = i_dbg_addr;
    assign dbg_bus.wdata = i_dbg_data;
    assign dbg_bus.sel = i_dbg_sel;
    assign o_dbg_ack = dbg_bus.ack;
    assign o_dbg_stall = dbg_bus.stall;
    assign o_dbg_err = dbg_bus.err;
    assign o_dbg_data = dbg_bus.rdata;

    // processor port on a, the high priority side
    wb_priority_arbiter u_arbiter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_a     (cpu_bus),
        .i_b     (dbg_bus),
        .o_bus   (sys_bus)
    );

    bus_address_decoder u_decoder (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_bus       (sys_bus),
        .o_mem       (mem_bus),
        .o_sys       (sys_regs_bus),
        .o_io        (io_bus),
        .o_err_pulse (err_pulse),
        .o_err_addr  (err_addr)
    );

    block_ram_slave u_ram (
        .i_clk (i_clk),
        .i_bus (mem_bus)
    );

    system_info_regs u_sys_regs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_bus       (sys_regs_bus),
        .i_err_pulse (err_pulse),
        .i_err_addr  (err_addr),
        .o_irq       (o_irq)
    );

    switch_led_port u_sw_led (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_bus      (io_bus),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

`default_nettype wire

/* bench/soc_bus_checks.svh */
`ifndef soc_bus_checks_svh
`define soc_bus_checks_svh

// print the error line, then the verdict, then stop
task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
endtask

task automatic report_mismatch(input string msg);
    stop_with_failure($sformatf("mismatch at %0t ns: %s", $time, msg));
endtask

// ack or err, and the cycle it arrived in after the accepted strobe
task automatic check_response(
    input logic  got_ack,
    input logic  got_err,
    input logic  exp_err,
    input int    latency,
    input string tag
);
    int exp_latency;
    exp_latency = exp_err ? 1 : 2;
    if (got_ack !== !exp_err || got_err !== exp_err) begin
        report_mismatch($sformatf("%s expected %s, got ack %b err %b",
                                  tag, exp_err ? "err" : "ack", got_ack, got_err));
    end else if (latency != exp_latency) begin
        report_mismatch($sformatf("%s response after %0d cycles, expected %0d",
                                  tag, latency, exp_latency));
    end
endtask

task automatic check_data(
    input logic [data_w-1:0] got,
    input logic [data_w-1:0] exp,
    input logic [data_w-1:0] mask,
    input string             tag
);
    if ((got & mask) !== (exp & mask)) begin
        report_mismatch($sformatf("%s data %h, expected %h under mask %h",
                                  tag, got, exp, mask));
    end
endtask

task automatic check_leds(
    input logic [io_w-1:0] got,
    input logic [io_w-1:0] exp,
    input string           tag
);
    if (got !== exp) begin
        report_mismatch($sformatf("%s leds %h, expected %h", tag, got, exp));
    end
endtask

// all request lines of one port, updated on the rising edge
task automatic drive_port(
    input logic              on_dbg,
    input logic              cyc,
    input logic              stb,
    input logic              we,
    input logic [addr_w-1:0] addr,
    input logic [sel_w-1:0]  sel,
    input logic [data_w-1:0] wdata
);
    if (on_dbg) begin
        dbg_cyc <= cyc;
        dbg_stb <= stb;
        dbg_we <= we;
        dbg_addr <= addr;
        dbg_sel <= sel;
        dbg_data <= wdata;
    end else begin
        cpu_cyc <= cyc;
        cpu_stb <= stb;
        cpu_we <= we;
        cpu_addr <= addr;
        cpu_sel <= sel;
        cpu_data <= wdata;
    end
endtask

// one single transfer on one port, latency counted from the accept edge
task automatic run_transfer(
    input logic               on_dbg,
    input logic               we,
    input logic [addr_w-1:0]  addr,
    input logic [sel_w-1:0]   sel,
    input logic [data_w-1:0]  wdata,
    output logic              got_ack,
    output logic              got_err,
    output logic [data_w-1:0] got_data,
    output int                latency,
    output logic              saw_stall
);
    logic stall_now;
    @(posedge clk);
    drive_port(on_dbg, 1'b1, 1'b1, we, addr, sel, wdata);
    saw_stall = 1'b0;
    latency = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    // hold the request while the other master owns the bus
    @(negedge clk);
    stall_now = on_dbg ? dbg_stall : cpu_stall;
    while (stall_now) begin
        saw_stall = 1'b1;
        @(negedge clk);
        stall_now = on_dbg ? dbg_stall : cpu_stall;
    end
    @(posedge clk);
    drive_port(on_dbg, 1'b1, 1'b0, we, addr, sel, wdata);
    // cyc stays up until the response
    while (!got_ack && !got_err) begin
        @(negedge clk);
        latency++;
        got_ack = on_dbg ? dbg_ack : cpu_ack;
        got_err = on_dbg ? dbg_err : cpu_err;
    end
    got_data = on_dbg ? dbg_rdata : cpu_rdata;
    @(posedge clk);
    drive_port(on_dbg, 1'b0, 1'b0, 1'b0, '0, '0, '0);
endtask

`endif

/* bench/soc_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb;
    import soc_bus_pkg::*;

    // pattern line layout and codes
    localparam int pattern_w = 144;
    localparam int max_lines = 64;
    localparam logic [3:0] port_dbg = 4'h1;
    localparam logic [3:0] port_pair = 4'h2;
    localparam logic [3:0] port_end = 4'hf;
    localparam logic [3:0] op_write = 4'h1;
    localparam logic [3:0] op_count = 4'h2;
    localparam logic [3:0] resp_err = 4'h1;
    localparam int reset_cycles = 16;
    localparam int cycles_per_line = 20;
    localparam logic [io_w-1:0] switch_value = 16'hc35a;

    logic clk;
    logic reset;
    logic cpu_cyc;
    logic cpu_stb;
    logic cpu_we;
    logic [addr_w-1:0] cpu_addr;
    logic [data_w-1:0] cpu_data;
    logic [sel_w-1:0] cpu_sel;
    logic cpu_ack;
    logic cpu_stall;
    logic cpu_err;
    logic [data_w-1:0] cpu_rdata;
    logic dbg_cyc;
    logic dbg_stb;
    logic dbg_we;
    logic [addr_w-1:0] dbg_addr;
    logic [data_w-1:0] dbg_data;
    logic [sel_w-1:0] dbg_sel;
    logic dbg_ack;
    logic dbg_stall;
    logic dbg_err;
    logic [data_w-1:0] dbg_rdata;
    logic [io_w-1:0] switches;
    logic [io_w-1:0] leds;
    logic irq;

    logic [pattern_w-1:0] patterns [0:max_lines-1];
    logic [data_w-1:0] last_count = '0;
    int cycle_count = 0;
    int cycle_limit = 0;

    `include "soc_bus_checks.svh"

    soc_bus_top DUT (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_cpu_cyc   (cpu_cyc),
        .i_cpu_stb   (cpu_stb),
        .i_cpu_we    (cpu_we),
        .i_cpu_addr  (cpu_addr),
        .i_cpu_data  (cpu_data),
        .i_cpu_sel   (cpu_sel),
        .o_cpu_ack   (cpu_ack),
        .o_cpu_stall (cpu_stall),
        .o_cpu_err   (cpu_err),
        .o_cpu_data  (cpu_rdata),
        .i_dbg_cyc   (dbg_cyc),
        .i_dbg_stb   (dbg_stb),
        .i_dbg_we    (dbg_we),
        .i_dbg_addr  (dbg_addr),
        .i_dbg_data  (dbg_data),
        .i_dbg_sel   (dbg_sel),
        .o_dbg_ack   (dbg_ack),
        .o_dbg_stall (dbg_stall),
        .o_dbg_err   (dbg_err),
        .o_dbg_data  (dbg_rdata),
        .i_switches  (switches),
        .o_leds      (leds),
        .o_irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_failure("timeout, transactions did not complete");
        end
    end

    // run one pattern line on one port and check what came back
    task automatic replay_line(
        input logic [pattern_w-1:0] line,
        input logic                 on_dbg,
        input int                   idx,
        output logic                saw_stall,
        output time                 done_at
    );
        logic [3:0] op;
        bus_addr_t addr;
        logic [sel_w-1:0] sel;
        logic [data_w-1:0] wdata;
        logic exp_err;
        logic [data_w-1:0] exp_data;
        logic [data_w-1:0] mask;
        logic got_ack;
        logic got_err;
        logic [data_w-1:0] got_data;
        int latency;
        string tag;
        op = line[139:136];
        addr = line[133:104];
        sel = line[103:100];
        wdata = line[99:68];
        exp_err = line[67:64] == resp_err;
        exp_data = line[63:32];
        mask = line[31:0];
        tag = $sformatf("pattern line %0d", idx);
        run_transfer(on_dbg, op == op_write, addr, sel, wdata,
                     got_ack, got_err, got_data, latency, saw_stall);
        done_at = $time;
        check_response(got_ack, got_err, exp_err, latency, tag);
        if (op != op_write) begin
            check_data(got_data, exp_data, mask, tag);
        end
        if (op == op_count) begin
            if (got_data <= last_count) begin
                report_mismatch($sformatf("%s counter %h not above earlier %h",
                                          tag, got_data, last_count));
            end
            last_count = got_data;
        end
        if (op == op_write && !exp_err && addr == addr_sw_led) begin
            check_leds(leds, wdata[io_w-1:0], tag);
        end
        // interrupt flag follows bit 0 of a write to its register
        if (op == op_write && !exp_err && addr.page_view.page == page_sys
                && addr.reg_view.index == sys_reg_irq) begin
            check_data({{(data_w-1){1'b0}}, irq}, {{(data_w-1){1'b0}}, wdata[0]},
                       '1, {tag, " irq"});
        end
    endtask

    initial begin
        int n_lines;
        int idx;
        logic stall_a;
        logic stall_b;
        time done_a;
        time done_b;
        reset <= 1'b1;
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        cpu_we <= 1'b0;
        cpu_addr <= '0;
        cpu_data <= '0;
        cpu_sel <= '0;
        dbg_cyc <= 1'b0;
        dbg_stb <= 1'b0;
        dbg_we <= 1'b0;
        dbg_addr <= '0;
        dbg_data <= '0;
        dbg_sel <= '0;
        switches <= switch_value;
        $readmemh("bench/bus_patterns.hex", patterns);
        n_lines = 0;
        while (n_lines < max_lines && patterns[n_lines][143:140] != port_end) begin
            n_lines++;
        end
        if (n_lines == max_lines) begin
            stop_with_failure("pattern file has no end line");
        end
        cycle_limit = n_lines * cycles_per_line + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_data({28'd0, cpu_ack, cpu_err, dbg_ack, dbg_err}, '0, '1, "responses after reset");
        check_data({{(data_w-1){1'b0}}, irq}, '0, '1, "irq after reset");
        check_leds(leds, '0, "after reset");
        idx = 0;
        while (idx < n_lines) begin
            if (patterns[idx][143:140] == port_pair) begin
                // both ports start in the same idle cycle
                fork
                    replay_line(patterns[idx], 1'b0, idx, stall_a, done_a);
                    replay_line(patterns[idx + 1], 1'b1, idx + 1, stall_b, done_b);
                join
                if (stall_a || !stall_b || done_a >= done_b) begin
                    report_mismatch($sformatf("pattern line %0d cpu stall %b dbg stall %b, %s",
                        idx, stall_a, stall_b, "processor port not served first"));
                end
                idx += 2;
            end else begin
                replay_line(patterns[idx], patterns[idx][143:140] == port_dbg, idx,
                            stall_a, done_a);
                idx += 1;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/bus_patterns.hex */
// port(0 cpu,1 dbg,2 cpu paired with next dbg line,f end)_op(0 rd,1 wr,2 counter rd)
// _word addr_sel_write data_resp(0 ack,1 err)_expected read data_compare mask
0_1_00000010_f_11223344_0_00000000_00000000
0_0_00000010_f_00000000_0_11223344_ffffffff
0_1_00000010_3_aabbccdd_0_00000000_00000000
0_0_00000010_f_00000000_0_1122ccdd_ffffffff
1_1_00000011_f_deadbeef_0_00000000_00000000
1_1_00000011_4_00550000_0_00000000_00000000
1_1_00000011_9_77000066_0_00000000_00000000
0_0_00000011_f_00000000_0_7755be66_ffffffff
0_0_00000111_f_00000000_0_7755be66_ffffffff
1_0_00001010_f_00000000_0_1122ccdd_ffffffff
0_0_00200000_f_00000000_0_20191028_ffffffff
0_2_00200003_f_00000000_0_00000000_00000000
1_1_00200001_f_5a5aa5a5_0_00000000_00000000
0_0_00200001_f_00000000_0_5a5aa5a5_ffffffff
0_1_00200004_f_00000001_0_00000000_00000000
0_0_00200004_f_00000000_0_00000001_ffffffff
1_1_00200004_f_00000000_0_00000000_00000000
1_0_00200004_f_00000000_0_00000000_ffffffff
0_0_00200007_f_00000000_0_00000000_ffffffff
0_0_00400000_f_00000000_1_00000000_00000000
0_0_00200002_f_00000000_0_01000000_ffffffff
1_0_00800000_f_00000000_1_00000000_00000000
1_0_00200002_f_00000000_0_02000000_ffffffff
0_0_00400001_f_00000000_0_0000c35a_ffffffff
0_1_00400001_f_1234beef_0_00000000_00000000
1_1_00400001_f_00000f0f_0_00000000_00000000
2_0_00000011_f_00000000_0_7755be66_ffffffff
1_0_00200001_f_00000000_0_5a5aa5a5_ffffffff
2_1_00000020_f_cafef00d_0_00000000_00000000
1_1_00200001_f_0badc0de_0_00000000_00000000
0_0_00000120_f_00000000_0_cafef00d_ffffffff
1_0_00200001_f_00000000_0_0badc0de_ffffffff
1_2_00200003_f_00000000_0_00000000_00000000
f_0_00000000_0_00000000_0_00000000_00000000

/* src.f */
+incdir+bench
logic/soc_bus_pkg.sv
logic/wb_bus_if.sv
logic/wb_priority_arbiter.sv
logic/bus_address_decoder.sv
logic/system_info_regs.sv
logic/switch_led_port.sv
logic/block_ram_slave.sv
logic/soc_bus_top.sv
bench/soc_bus_tb.sv

/* Makefile */
# Verilator build of the bus fabric testbench, run from the project root

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module soc_bus_tb \
		-Mdir obj_dir -f src.f

run: compile
	./obj_dir/Vsoc_bus_tb

clean:
	rm -rf obj_dir
